//--- sim.f
+incdir+rtl
rtl/rp_pkg.sv
rtl/rp_bus_decoder.sv
rtl/rp_housekeeping.sv
rtl/rp_adc_frontend.sv
rtl/rp_signal_router.sv
rtl/rp_dac_backend.sv
rtl/rp_analog_top.sv
testbench/rp_analog_assertions.sv
testbench/tb_rp_analog_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the analog top testbench with verilator and run it
# exits with 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module tb_rp_analog_top \
  -f sim.f \
  || { echo "verilator build failed"; exit 1; }

output="$(./obj_dir/Vtb_rp_analog_top 2>&1)"
echo "$output"

echo "$output" | grep -qx "Test passed" && exit 0 || exit 1

//--- testbench/tb_rp_analog_top.sv
/* testbench for the analog board top level
   drives the system bus and adc pins, checks bus replies and dac codes */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module tb_rp_analog_top;

  localparam int ACK_TIMEOUT  = 16;         // cycles, bus ack
  localparam int LOOP_TIMEOUT = 16;         // cycles, loopback settling
  localparam rp_pkg::region_t HK_REGION = rp_pkg::region_t'(`RP_REGION_HK);
  localparam rp_pkg::region_t RT_REGION = rp_pkg::region_t'(`RP_REGION_ROUTER);

  logic              adc_clk;
  logic              rst_n_i;
  rp_pkg::adc_pin_t  adc_dat_a_i;
  rp_pkg::adc_pin_t  adc_dat_b_i;
  rp_pkg::dac_code_t dac_dat_a_o;
  rp_pkg::dac_code_t dac_dat_b_o;
  rp_pkg::led_t      led_o;
  rp_pkg::bus_addr_t sys_addr_i;
  rp_pkg::bus_data_t sys_wdata_i;
  logic              sys_wen_i;
  logic              sys_ren_i;
  rp_pkg::bus_data_t sys_rdata_o;
  logic              sys_ack_o;
  logic              sys_err_o;

  int        checks = 0;
  int        errors = 0;
  bit [31:0] rnd;

  rp_analog_top UUT (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o      ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  )
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;         // 40 ns
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic rp_pkg::bus_addr_t reg_addr(input rp_pkg::region_t region,
                                                 input logic [7:0]      ofs);
    rp_pkg::bus_addr_t a;
    a = '0;
    a[`RP_REGION_MSB:`RP_REGION_LSB] = region;
    a[7:0] = ofs;
    return a;
  endfunction

  // sample zero sits at 14'h1FFF on the pins
  function automatic rp_pkg::dac_code_t sample_code(input rp_pkg::sample_t s);
    return rp_pkg::dac_code_t'(s) ^ 14'h1FFF;
  endfunction

  function automatic rp_pkg::bus_data_t sample_word(input rp_pkg::sample_t s);
    return {{(`RP_BUS_W-`RP_SAMPLE_W){s[`RP_SAMPLE_W-1]}}, s};  // sign extended
  endfunction

  function automatic rp_pkg::bus_data_t src_word(input rp_pkg::route_src_e s);
    return {{(`RP_BUS_W-2){1'b0}}, s};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input rp_pkg::bus_data_t got,
                            input rp_pkg::bus_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_code(input string name, input rp_pkg::dac_code_t got,
                            input rp_pkg::dac_code_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input rp_pkg::led_t got,
                           input rp_pkg::led_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d error(s)", name, errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////////////////////

  // one-cycle strobe, address and data held until ack
  task automatic bus_transfer(input logic write, input rp_pkg::bus_addr_t addr,
                              input rp_pkg::bus_data_t wdata,
                              output rp_pkg::bus_data_t rdata, output logic err);
    int   cnt;
    logic got;
    cnt   = 0;
    got   = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= write;
    sys_ren_i   <= ~write;
    while (!got && cnt < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);                   // replies are stable here
      if (sys_ack_o)
      begin
        got   = 1'b1;
        rdata = sys_rdata_o;
        err   = sys_err_o;
      end
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;
      sys_ren_i <= 1'b0;
      cnt++;
    end
    if (!got)
    begin
      errors++;
      $display("timeout at %0d ns: no bus ack for address 0x%08h", $time, addr);
    end
  endtask

  task automatic bus_write(input rp_pkg::bus_addr_t addr, input rp_pkg::bus_data_t data,
                           output logic err);
    rp_pkg::bus_data_t unused_rdata;
    bus_transfer(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic bus_read(input rp_pkg::bus_addr_t addr, output rp_pkg::bus_data_t data,
                          output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    int                e0;
    rp_pkg::bus_data_t rdata;
    logic              err;
    e0 = errors;
    @(negedge adc_clk);
    check_code("dac_dat_a_o", dac_dat_a_o, 14'h1FFF);   // sample zero
    check_code("dac_dat_b_o", dac_dat_b_o, 14'h1FFF);
    check_led("led_o", led_o, '0);
    check_bit("sys_ack_o", sys_ack_o, 1'b0);
    check_bit("sys_err_o", sys_err_o, 1'b0);
    bus_read(reg_addr(HK_REGION, 8'h00), rdata, err);
    check_data("hk id", rdata, `RP_HK_ID);
    check_bit("sys_err_o", err, 1'b0);
    report_test("reset values", e0);
  endtask

  task automatic led_register();
    int                e0;
    rp_pkg::led_t      v;
    rp_pkg::bus_data_t rdata;
    logic              err;
    e0  = errors;
    rnd = $urandom;
    v   = rnd[`RP_LED_W-1:0];
    bus_write(reg_addr(HK_REGION, `RP_HK_LED_OFS), {{(`RP_BUS_W-`RP_LED_W){1'b0}}, v}, err);
    check_bit("sys_err_o", err, 1'b0);
    bus_read(reg_addr(HK_REGION, `RP_HK_LED_OFS), rdata, err);
    check_data("hk led", rdata, {{(`RP_BUS_W-`RP_LED_W){1'b0}}, v});
    @(negedge adc_clk);
    check_led("led_o", led_o, v);
    bus_read(reg_addr(HK_REGION, 8'h10), rdata, err);     // no register here
    check_bit("sys_err_o", err, 1'b1);
    check_data("hk unmapped", rdata, '0);
    report_test("led register", e0);
  endtask

  task automatic unused_regions();
    int                e0;
    rp_pkg::led_t      v;
    rp_pkg::bus_data_t rdata;
    logic              err;
    e0  = errors;
    rnd = $urandom;
    v   = rnd[`RP_LED_W-1:0];
    bus_read(reg_addr(3'd5, 8'h00), rdata, err);
    check_data("region 5 read", rdata, '0);
    check_bit("sys_err_o", err, 1'b0);
    bus_write(reg_addr(HK_REGION, `RP_HK_LED_OFS), {{(`RP_BUS_W-`RP_LED_W){1'b0}}, v}, err);
    // same offsets as live registers, other region
    bus_write(reg_addr(3'd6, `RP_HK_LED_OFS), {{(`RP_BUS_W-`RP_LED_W){1'b0}}, ~v}, err);
    check_bit("sys_err_o", err, 1'b0);
    bus_write(reg_addr(3'd6, `RP_RT_SRC_A_OFS), src_word(rp_pkg::src_dc), err);
    bus_read(reg_addr(HK_REGION, `RP_HK_LED_OFS), rdata, err);
    check_data("hk led", rdata, {{(`RP_BUS_W-`RP_LED_W){1'b0}}, v});
    @(negedge adc_clk);
    check_led("led_o", led_o, v);
    bus_read(reg_addr(RT_REGION, `RP_RT_SRC_A_OFS), rdata, err);
    check_data("router src a", rdata, src_word(rp_pkg::src_off));
    report_test("unused regions", e0);
  endtask

  task automatic adc_cross();
    int                e0;
    rp_pkg::adc_pin_t  pa;
    rp_pkg::adc_pin_t  pb;
    rp_pkg::adc_pin_t  prev_a;
    rp_pkg::adc_pin_t  prev_b;
    logic              err;
    e0     = errors;
    prev_a = adc_dat_a_i;
    prev_b = adc_dat_b_i;
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_A_OFS), src_word(rp_pkg::src_adc_b), err);
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_B_OFS), src_word(rp_pkg::src_adc_a), err);
    for (int i = 0; i < 4; i++)
    begin
      rnd = $urandom;
      pa  = rnd[15:0];
      pb  = rnd[31:16];
      @(posedge adc_clk);
      adc_dat_a_i <= pa;
      adc_dat_b_i <= pb;
      repeat (2) @(posedge adc_clk);
      @(negedge adc_clk);                   // two stages in, old codes still out
      check_code("dac_dat_a_o", dac_dat_a_o, prev_b[15:2]);
      check_code("dac_dat_b_o", dac_dat_b_o, prev_a[15:2]);
      @(posedge adc_clk);
      @(negedge adc_clk);
      check_code("dac_dat_a_o", dac_dat_a_o, pb[15:2]);
      check_code("dac_dat_b_o", dac_dat_b_o, pa[15:2]);
      prev_a = pa;
      prev_b = pb;
    end
    report_test("adc cross", e0);
  endtask

  task automatic dc_and_off();
    int                e0;
    rp_pkg::sample_t   v;
    rp_pkg::bus_data_t rdata;
    logic              err;
    e0  = errors;
    rnd = $urandom;
    v   = rnd[`RP_SAMPLE_W-1:0];
    bus_write(reg_addr(RT_REGION, `RP_RT_DC_A_OFS), sample_word(v), err);
    bus_read(reg_addr(RT_REGION, `RP_RT_DC_A_OFS), rdata, err);
    check_data("router dc a", rdata, sample_word(v));
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_A_OFS), src_word(rp_pkg::src_dc), err);
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_B_OFS), src_word(rp_pkg::src_off), err);
    @(posedge adc_clk);                     // router then dac register
    @(negedge adc_clk);
    check_code("dac_dat_a_o", dac_dat_a_o, sample_code(v));
    check_code("dac_dat_b_o", dac_dat_b_o, 14'h1FFF);
    report_test("dc and off", e0);
  endtask

  task automatic loopback();
    int                e0;
    int                cnt;
    rp_pkg::sample_t   v;
    rp_pkg::bus_data_t rdata;
    logic              err;
    e0  = errors;
    cnt = 0;
    rnd = $urandom;
    v   = rnd[`RP_SAMPLE_W-1:0];
    bus_write(reg_addr(RT_REGION, `RP_RT_DC_A_OFS), sample_word(v), err);
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_A_OFS), src_word(rp_pkg::src_dc), err);
    bus_write(reg_addr(RT_REGION, `RP_RT_SRC_B_OFS), src_word(rp_pkg::src_adc_a), err);
    bus_write(reg_addr(HK_REGION, `RP_HK_LOOP_OFS), 32'd1, err);
    bus_read(reg_addr(HK_REGION, `RP_HK_LOOP_OFS), rdata, err);
    check_data("hk loopback", rdata, 32'd1);
    @(posedge adc_clk);
    adc_dat_a_i <= rnd[15:0];               // pins must not matter now
    adc_dat_b_i <= rnd[31:16];
    @(negedge adc_clk);
    while (dac_dat_b_o !== dac_dat_a_o && cnt < LOOP_TIMEOUT)
    begin
      @(negedge adc_clk);
      cnt++;
    end
    if (dac_dat_b_o !== dac_dat_a_o)
    begin
      errors++;
      $display("timeout at %0d ns: channel B never followed channel A in loopback", $time);
    end
    check_code("dac_dat_a_o", dac_dat_a_o, sample_code(v));
    check_code("dac_dat_b_o", dac_dat_b_o, sample_code(v));
    rnd = $urandom;
    @(posedge adc_clk);
    adc_dat_a_i <= rnd[15:0];
    adc_dat_b_i <= rnd[31:16];
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    check_code("dac_dat_b_o", dac_dat_b_o, sample_code(v));
    report_test("loopback", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rnd = $urandom(32'h2887_d423);          // seeds the run
    rst_n_i     <= 1'b0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    repeat (3) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    reset_values();
    led_register();
    unused_regions();
    adc_cross();
    dc_and_off();
    loopback();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/rp_analog_assertions.sv
/* bound checks for the analog top level
   bus reply rules and known dac outputs */

`timescale 1ns/1ps
`default_nettype none

module rp_analog_assertions (
  input wire                    adc_clk,
  input wire                    rst_n_i,
  input wire                    sys_ack_i,
  input wire                    sys_err_i,
  input wire                    hk_wen_i,
  input wire                    hk_ren_i,
  input wire                    rt_wen_i,
  input wire                    rt_ren_i,
  input wire rp_pkg::dac_code_t dac_a_i,
  input wire rp_pkg::dac_code_t dac_b_i
);

  // error only ever rides on an ack
  err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_err_i |-> sys_ack_i)
    else $error("bus err without ack");

  // slave reply reaches the master one cycle after the strobe
  hk_ack_next: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (hk_wen_i || hk_ren_i) |=> sys_ack_i)
    else $error("housekeeping strobe without bus ack on next cycle");

  rt_ack_next: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (rt_wen_i || rt_ren_i) |=> sys_ack_i)
    else $error("router strobe without bus ack on next cycle");

  dac_known: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown({dac_a_i, dac_b_i}))
    else $error("dac output unknown");

endmodule

bind rp_analog_top rp_analog_assertions i_assertions (
  .adc_clk   (adc_clk    ),
  .rst_n_i   (rst_n_i    ),
  .sys_ack_i (sys_ack_o  ),
  .sys_err_i (sys_err_o  ),
  .hk_wen_i  (hk_wen     ),
  .hk_ren_i  (hk_ren     ),
  .rt_wen_i  (rt_wen     ),
  .rt_ren_i  (rt_ren     ),
  .dac_a_i   (dac_dat_a_o),
  .dac_b_i   (dac_dat_b_o)
);

`default_nettype wire

//--- rtl/rp_analog_top.sv
/* analog board top level
   bus decoder, housekeeping, adc front end, signal router and dac back end */

`timescale 1ns/1ps
`default_nettype none

module rp_analog_top (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  // converters
  input  wire rp_pkg::adc_pin_t  adc_dat_a_i,
  input  wire rp_pkg::adc_pin_t  adc_dat_b_i,
  output rp_pkg::dac_code_t      dac_dat_a_o,
  output rp_pkg::dac_code_t      dac_dat_b_o,
  output rp_pkg::led_t           led_o,
  // system bus
  input  wire rp_pkg::bus_addr_t sys_addr_i,
  input  wire rp_pkg::bus_data_t sys_wdata_i,
  input  wire                    sys_wen_i,
  input  wire                    sys_ren_i,
  output rp_pkg::bus_data_t      sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  ////////////////////////////////////////////////////////////////////////////
  // local wires
  ////////////////////////////////////////////////////////////////////////////

  logic              hk_wen;
  logic              hk_ren;
  rp_pkg::bus_data_t hk_rdata;
  logic              hk_ack;
  logic              hk_err;
  logic              rt_wen;
  logic              rt_ren;
  rp_pkg::bus_data_t rt_rdata;
  logic              rt_ack;
  logic              rt_err;

  logic              digital_loop;
  rp_pkg::sample_t   adc_a;           // front end to router
  rp_pkg::sample_t   adc_b;
  rp_pkg::sample_t   dac_a;           // router to back end and loopback
  rp_pkg::sample_t   dac_b;

  rp_bus_decoder i_dec (
    .sys_addr_i  (sys_addr_i ),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .hk_wen_o    (hk_wen     ),
    .hk_ren_o    (hk_ren     ),
    .rt_wen_o    (rt_wen     ),
    .rt_ren_o    (rt_ren     ),
    .hk_rdata_i  (hk_rdata   ),
    .hk_ack_i    (hk_ack     ),
    .hk_err_i    (hk_err     ),
    .rt_rdata_i  (rt_rdata   ),
    .rt_ack_i    (rt_ack     ),
    .rt_err_i    (rt_err     ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  )
  );

  rp_housekeeping i_hk (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .addr_i         (sys_addr_i  ),
    .wdata_i        (sys_wdata_i ),
    .wen_i          (hk_wen      ),
    .ren_i          (hk_ren      ),
    .rdata_o        (hk_rdata    ),
    .ack_o          (hk_ack      ),
    .err_o          (hk_err      ),
    .led_o          (led_o       ),
    .digital_loop_o (digital_loop)
  );

  rp_adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_dat_a_i    (adc_dat_a_i ),
    .adc_dat_b_i    (adc_dat_b_i ),
    .loop_a_i       (dac_a       ),
    .loop_b_i       (dac_b       ),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a       ),
    .adc_b_o        (adc_b       )
  );

  rp_signal_router i_rt (
    .adc_clk (adc_clk    ),
    .rst_n_i (rst_n_i    ),
    .addr_i  (sys_addr_i ),
    .wdata_i (sys_wdata_i),
    .wen_i   (rt_wen     ),
    .ren_i   (rt_ren     ),
    .rdata_o (rt_rdata   ),
    .ack_o   (rt_ack     ),
    .err_o   (rt_err     ),
    .adc_a_i (adc_a      ),
    .adc_b_i (adc_b      ),
    .out_a_o (dac_a      ),
    .out_b_o (dac_b      )
  );

  rp_dac_backend i_dac (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .dac_a_i     (dac_a      ),
    .dac_b_i     (dac_b      ),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

//--- rtl/rp_dac_backend.sv
/* dac back end
   output registers with two's complement to offset code conversion */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_dac_backend (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  wire rp_pkg::sample_t dac_a_i,
  input  wire rp_pkg::sample_t dac_b_i,
  output rp_pkg::dac_code_t    dac_dat_a_o,
  output rp_pkg::dac_code_t    dac_dat_b_o
);

  // signed to negative slope, msb kept
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= `RP_DAC_ZERO_CODE;            // sample zero on the pins
      dac_dat_b_o <= `RP_DAC_ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= {dac_a_i[`RP_SAMPLE_W-1], ~dac_a_i[`RP_SAMPLE_W-2:0]};
      dac_dat_b_o <= {dac_b_i[`RP_SAMPLE_W-1], ~dac_b_i[`RP_SAMPLE_W-2:0]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/rp_signal_router.sv
/* signal router in region 3
   per dac channel source select and dc value, registered routing */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_signal_router (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  // region bus
  input  wire rp_pkg::bus_addr_t addr_i,
  input  wire rp_pkg::bus_data_t wdata_i,
  input  wire                    wen_i,
  input  wire                    ren_i,
  output rp_pkg::bus_data_t      rdata_o,
  output logic                   ack_o,
  output logic                   err_o,
  // samples
  input  wire rp_pkg::sample_t   adc_a_i,
  input  wire rp_pkg::sample_t   adc_b_i,
  output rp_pkg::sample_t        out_a_o,
  output rp_pkg::sample_t        out_b_o
);

  rp_pkg::route_src_e src_a;
  rp_pkg::route_src_e src_b;
  rp_pkg::sample_t    dc_a;
  rp_pkg::sample_t    dc_b;
  logic [7:0]         ofs;
  logic               ofs_hit;

  // one channel's pick, zero when off
  function automatic rp_pkg::sample_t route_pick(input rp_pkg::route_src_e src,
                                                 input rp_pkg::sample_t    a,
                                                 input rp_pkg::sample_t    b,
                                                 input rp_pkg::sample_t    dc);
    case (src)
      rp_pkg::src_adc_a: route_pick = a;
      rp_pkg::src_adc_b: route_pick = b;
      rp_pkg::src_dc:    route_pick = dc;
      default:           route_pick = '0;
    endcase
  endfunction

  assign ofs     = addr_i[7:0];
  assign ofs_hit = (ofs == `RP_RT_SRC_A_OFS) | (ofs == `RP_RT_SRC_B_OFS)
                 | (ofs == `RP_RT_DC_A_OFS)  | (ofs == `RP_RT_DC_B_OFS);

  ////////////////////////////////////////////////////////////////////////////
  // registers and bus reply
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      src_a   <= rp_pkg::src_off;
      src_b   <= rp_pkg::src_off;
      dc_a    <= '0;
      dc_b    <= '0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;
      err_o   <= (wen_i | ren_i) & ~ofs_hit;
      rdata_o <= '0;

      if (wen_i)
      begin
        case (ofs)
          `RP_RT_SRC_A_OFS: src_a <= rp_pkg::route_src_e'(wdata_i[1:0]);
          `RP_RT_SRC_B_OFS: src_b <= rp_pkg::route_src_e'(wdata_i[1:0]);
          `RP_RT_DC_A_OFS:  dc_a  <= wdata_i[`RP_SAMPLE_W-1:0];
          `RP_RT_DC_B_OFS:  dc_b  <= wdata_i[`RP_SAMPLE_W-1:0];
          default:          ;                         // unmapped, err only
        endcase
      end

      if (ren_i)
      begin
        case (ofs)                                    // dc reads sign extended
          `RP_RT_SRC_A_OFS: rdata_o <= {{(`RP_BUS_W-2){1'b0}}, src_a};
          `RP_RT_SRC_B_OFS: rdata_o <= {{(`RP_BUS_W-2){1'b0}}, src_b};
          `RP_RT_DC_A_OFS:  rdata_o <= {{(`RP_BUS_W-`RP_SAMPLE_W){dc_a[`RP_SAMPLE_W-1]}}, dc_a};
          `RP_RT_DC_B_OFS:  rdata_o <= {{(`RP_BUS_W-`RP_SAMPLE_W){dc_b[`RP_SAMPLE_W-1]}}, dc_b};
          default:          rdata_o <= '0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // routing stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out_a_o <= '0;
      out_b_o <= '0;
    end
    else
    begin
      out_a_o <= route_pick(src_a, adc_a_i, adc_b_i, dc_a);
      out_b_o <= route_pick(src_b, adc_a_i, adc_b_i, dc_b);
    end
  end

endmodule

`default_nettype wire

//--- rtl/rp_adc_frontend.sv
/* adc front end
   pin registers, offset code to two's complement and loopback select */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_adc_frontend (
  input  wire                   adc_clk,
  input  wire                   rst_n_i,
  input  wire rp_pkg::adc_pin_t adc_dat_a_i,
  input  wire rp_pkg::adc_pin_t adc_dat_b_i,
  input  wire rp_pkg::sample_t  loop_a_i,      // dac-bound samples
  input  wire rp_pkg::sample_t  loop_b_i,
  input  wire                   digital_loop_i,
  output rp_pkg::sample_t       adc_a_o,
  output rp_pkg::sample_t       adc_b_o
);

  rp_pkg::dac_code_t adc_dat_a;
  rp_pkg::dac_code_t adc_dat_b;

  // io registers, lowest 2 pin bits dropped
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_dat_a <= `RP_DAC_ZERO_CODE;              // mid scale
      adc_dat_b <= `RP_DAC_ZERO_CODE;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i[`RP_ADC_PIN_W-1 -: `RP_SAMPLE_W];
      adc_dat_b <= adc_dat_b_i[`RP_ADC_PIN_W-1 -: `RP_SAMPLE_W];
    end
  end

  // negative slope code, keep msb and flip the rest
  assign adc_a_o = digital_loop_i ? loop_a_i
                 : {adc_dat_a[`RP_SAMPLE_W-1], ~adc_dat_a[`RP_SAMPLE_W-2:0]};
  assign adc_b_o = digital_loop_i ? loop_b_i
                 : {adc_dat_b[`RP_SAMPLE_W-1], ~adc_dat_b[`RP_SAMPLE_W-2:0]};

endmodule

`default_nettype wire

//--- rtl/rp_housekeeping.sv
/* housekeeping registers in region 0
   read-only id, led register and digital loopback switch */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_housekeeping (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  // region bus
  input  wire rp_pkg::bus_addr_t addr_i,
  input  wire rp_pkg::bus_data_t wdata_i,
  input  wire                    wen_i,
  input  wire                    ren_i,
  output rp_pkg::bus_data_t      rdata_o,
  output logic                   ack_o,
  output logic                   err_o,
  // config outputs
  output rp_pkg::led_t           led_o,
  output logic                   digital_loop_o
);

  logic [7:0] ofs;
  logic       ofs_hit;

  assign ofs = addr_i[7:0];                           // only low byte decoded

  assign ofs_hit = (ofs == `RP_HK_ID_OFS)
                 | (ofs == `RP_HK_LOOP_OFS)
                 | (ofs == `RP_HK_LED_OFS);

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;
      ack_o          <= 1'b0;
      err_o          <= 1'b0;
      rdata_o        <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;                       // one cycle after strobe
      err_o   <= (wen_i | ren_i) & ~ofs_hit;
      rdata_o <= '0;

      if (wen_i)
      begin
        if (ofs == `RP_HK_LOOP_OFS) digital_loop_o <= wdata_i[0];
        if (ofs == `RP_HK_LED_OFS)  led_o          <= wdata_i[`RP_LED_W-1:0];
      end

      if (ren_i)
      begin
        case (ofs)
          `RP_HK_ID_OFS:   rdata_o <= `RP_HK_ID;
          `RP_HK_LOOP_OFS: rdata_o <= {{(`RP_BUS_W-1){1'b0}}, digital_loop_o};
          `RP_HK_LED_OFS:  rdata_o <= {{(`RP_BUS_W-`RP_LED_W){1'b0}}, led_o};
          default:         rdata_o <= '0;             // err flags this one
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rp_bus_decoder.sv
/* system bus decoder
   splits the bus into eight 1 MB regions and muxes the slave replies */

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_bus_decoder (
  input  wire rp_pkg::bus_addr_t sys_addr_i,
  input  wire                    sys_wen_i,
  input  wire                    sys_ren_i,
  // strobes to live slaves
  output logic                   hk_wen_o,
  output logic                   hk_ren_o,
  output logic                   rt_wen_o,
  output logic                   rt_ren_o,
  // slave replies
  input  wire rp_pkg::bus_data_t hk_rdata_i,
  input  wire                    hk_ack_i,
  input  wire                    hk_err_i,
  input  wire rp_pkg::bus_data_t rt_rdata_i,
  input  wire                    rt_ack_i,
  input  wire                    rt_err_i,
  // back to master
  output rp_pkg::bus_data_t      sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  rp_pkg::region_t            region;
  logic [`RP_NUM_REGIONS-1:0] cs;       // one-hot region select
  logic                       cs_hk;
  logic                       cs_rt;
  logic                       cs_unused;
  logic                       strobe;

  assign region = sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign cs     = {{(`RP_NUM_REGIONS-1){1'b0}}, 1'b1} << region;

  assign cs_hk     = cs[`RP_REGION_HK];
  assign cs_rt     = cs[`RP_REGION_ROUTER];
  assign cs_unused = ~(cs_hk | cs_rt);    // the other six regions
  assign strobe    = sys_wen_i | sys_ren_i;

  ////////////////////////////////////////////////////////////////////////////
  // strobe gating
  ////////////////////////////////////////////////////////////////////////////

  assign hk_wen_o = sys_wen_i & cs_hk;
  assign hk_ren_o = sys_ren_i & cs_hk;
  assign rt_wen_o = sys_wen_i & cs_rt;
  assign rt_ren_o = sys_ren_i & cs_rt;

  ////////////////////////////////////////////////////////////////////////////
  // reply mux
  ////////////////////////////////////////////////////////////////////////////

  // unused regions read as zero
  assign sys_rdata_o = ({`RP_BUS_W{cs_hk}} & hk_rdata_i)
                     | ({`RP_BUS_W{cs_rt}} & rt_rdata_i);

  assign sys_ack_o = (cs_hk & hk_ack_i)
                   | (cs_rt & rt_ack_i)
                   | (cs_unused & strobe);  // immediate ack, same cycle as strobe

  assign sys_err_o = (cs_hk & hk_err_i) | (cs_rt & rt_err_i);

endmodule

`default_nettype wire

//--- rtl/rp_pkg.sv
/* analog top types
   vector types with a meaning on the bus and data path, router source enum */

`default_nettype none

`include "rp_config.svh"

package rp_pkg;

  // data path
  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;   // two's complement
  typedef logic        [`RP_SAMPLE_W-1:0] dac_code_t; // negative slope offset code
  typedef logic        [`RP_ADC_PIN_W-1:0] adc_pin_t; // raw pins

  // system bus
  typedef logic [`RP_BUS_W-1:0] bus_addr_t;
  typedef logic [`RP_BUS_W-1:0] bus_data_t;
  typedef logic [`RP_REGION_MSB-`RP_REGION_LSB:0] region_t;

  typedef logic [`RP_LED_W-1:0] led_t;

  // dac channel source select
  typedef enum logic [1:0] {
    src_off   = 2'd0,
    src_adc_a = 2'd1,
    src_adc_b = 2'd2,
    src_dc    = 2'd3
  } route_src_e;

endpackage

`default_nettype wire

//--- rtl/rp_config.svh
/* analog top configuration
   sample and bus widths, bus region map, register offsets and board id */

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

// data path widths
`define RP_SAMPLE_W       14            // converter sample width
`define RP_ADC_PIN_W      16            // raw adc pin word, 2 lsbs unused
`define RP_DAC_ZERO_CODE  14'h1FFF      // offset code of sample zero
`define RP_LED_W          8

// system bus
`define RP_BUS_W          32
`define RP_REGION_MSB     22            // 1 MB regions
`define RP_REGION_LSB     20
`define RP_NUM_REGIONS    8
`define RP_REGION_HK      0             // housekeeping
`define RP_REGION_ROUTER  3             // dsp stand-in

// housekeeping offsets
`define RP_HK_ID          32'h7270_0114
`define RP_HK_ID_OFS      8'h00
`define RP_HK_LOOP_OFS    8'h04         // bit 0
`define RP_HK_LED_OFS     8'h08

// router offsets
`define RP_RT_SRC_A_OFS   8'h00
`define RP_RT_SRC_B_OFS   8'h04
`define RP_RT_DC_A_OFS    8'h08
`define RP_RT_DC_B_OFS    8'h0C

`endif
